// ==== project.f ====
+incdir+.
lcd_pkg.sv
lcd_field_formatter.sv
lcd_sequencer.sv
lcd_control.sv
tb_clock_gen.sv
tb_lcd_control.sv

// ==== tb_lcd_control.sv ====
`default_nettype none

`include "lcd_config.svh"

module tb_lcd_control;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAMES = 8;
    // one extra frame for the first value test, one for init and labels
    localparam int WATCHDOG_CYCLES = (FRAMES + 2) * 40 * 7 + 1000;

    logic                clk;
    logic                rst_n;
    logic                en_lcd;
    logic                done_piso;
    logic                done_sipo;
    logic                done_lcd;
    lcd_pkg::conv_word_t conv;
    lcd_pkg::lcd_byte_t  data;
    logic                o_en_lcd;
    lcd_pkg::lcd_byte_t  o_data;
    lcd_pkg::lcd_func_t  o_func;
    logic                o_done;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int first_err = 0;
    // bytes taken by the responder, and bytes the model predicts
    lcd_pkg::lcd_byte_t got_data[$];
    lcd_pkg::lcd_func_t got_func[$];
    lcd_pkg::lcd_byte_t exp_data[$];
    lcd_pkg::lcd_func_t exp_func[$];

    tb_clock_gen u_clock (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    lcd_control UUT (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_en_lcd    (en_lcd),
        .i_done_piso (done_piso),
        .i_done_sipo (done_sipo),
        .i_done_lcd  (done_lcd),
        .i_conv      (conv),
        .i_data      (data),
        .o_en_lcd    (o_en_lcd),
        .o_data      (o_data),
        .o_func      (o_func),
        .o_done      (o_done)
    );

    // upper case hex digit by table lookup
    function automatic lcd_pkg::lcd_byte_t hex_char(input logic [3:0] nib);
        string digits;
        digits = "0123456789ABCDEF";
        return digits[nib];
    endfunction

    task automatic expect_byte(input lcd_pkg::lcd_byte_t d, input lcd_pkg::lcd_func_t f);
        exp_data.push_back(d);
        exp_func.push_back(f);
    endtask

    // cursor command, then the label text
    task automatic expect_label_line(input string text, input lcd_pkg::lcd_byte_t cursor);
        expect_byte(cursor, `LCD_FUNC_SETCURSOR);
        for (int i = 0; i < text.len(); i++)
            expect_byte(text[i], `LCD_FUNC_DATA);
    endtask

    task automatic expect_value_frame(input lcd_pkg::conv_word_t c, input lcd_pkg::lcd_byte_t d);
        expect_byte(`LCD_CMD_CLEAR, `LCD_FUNC_CMD);
        expect_byte(`LCD_CMD_LINE1 + `LCD_VALUE_COL, `LCD_FUNC_CMD);
        expect_byte("0", `LCD_FUNC_DATA);
        expect_byte("x", `LCD_FUNC_DATA);
        // top nibble shown first
        for (int n = 3; n >= 0; n--)
            expect_byte(hex_char(c[n*4 +: 4]), `LCD_FUNC_DATA);
        expect_byte(`LCD_CMD_LINE2 + `LCD_VALUE_COL, `LCD_FUNC_CMD);
        expect_byte("0", `LCD_FUNC_DATA);
        expect_byte("x", `LCD_FUNC_DATA);
        expect_byte(hex_char(d[7:4]), `LCD_FUNC_DATA);
        expect_byte(hex_char(d[3:0]), `LCD_FUNC_DATA);
    endtask

    // poll at falling edges with about seven cycles allowed per byte
    task automatic wait_bytes(input int n);
        int cycles;
        cycles = 0;
        while (got_data.size() < n && cycles < n * 7 + 20) begin
            @(negedge clk);
            cycles++;
        end
        if (got_data.size() < n) begin
            $display("no response: %0d of %0d bytes accepted after %0d cycles, at %0t ns",
                     got_data.size(), n, cycles, $time);
            errors++;
        end
    endtask

    task automatic compare_bytes();
        lcd_pkg::lcd_byte_t ed;
        lcd_pkg::lcd_byte_t gd;
        lcd_pkg::lcd_func_t ef;
        lcd_pkg::lcd_func_t gf;
        int idx;
        idx = 0;
        while (exp_data.size() > 0) begin
            ed = exp_data.pop_front();
            ef = exp_func.pop_front();
            if (got_data.size() == 0) begin
                $display("byte %0d (0x%02h) was never accepted", idx, ed);
                errors++;
            end else begin
                gd = got_data.pop_front();
                gf = got_func.pop_front();
                if (gd !== ed || gf !== ef) begin
                    $display("[FAIL] %0t ns: byte %0d is 0x%02h func %0d, want 0x%02h func %0d",
                             $time, idx, gd, gf, ed, ef);
                    errors++;
                end
            end
            idx++;
        end
    endtask

    // no byte offered and done flag steady
    task automatic check_quiet(input int cycles, input logic done_level);
        repeat (cycles) begin
            @(negedge clk);
            if (o_en_lcd !== 1'b0 || o_done !== done_level || got_data.size() != 0) begin
                $display("[FAIL] %0t ns: activity while idle, en %b done %b",
                         $time, o_en_lcd, o_done);
                errors++;
            end
        end
    endtask

    // inputs change away from the pulse value right after it
    task automatic pulse_conv(input lcd_pkg::conv_word_t value);
        @(posedge clk);
        #2;
        conv = value;
        done_piso = 1'b1;
        @(posedge clk);
        #2;
        done_piso = 1'b0;
        conv = $urandom;
    endtask

    task automatic pulse_data(input lcd_pkg::lcd_byte_t value);
        @(posedge clk);
        #2;
        data = value;
        done_sipo = 1'b1;
        @(posedge clk);
        #2;
        done_sipo = 1'b0;
        data = $urandom;
    endtask

    task automatic run_frame(input lcd_pkg::conv_word_t c, input lcd_pkg::lcd_byte_t d);
        int cycles;
        pulse_conv(c);
        @(negedge clk);
        if (o_done !== 1'b0) begin
            $display("[FAIL] %0t ns: done still high after conversion pulse", $time);
            errors++;
        end
        repeat ($urandom % 4) @(posedge clk);
        pulse_data(d);
        expect_value_frame(c, d);
        wait_bytes(13);
        if (o_done !== 1'b0) begin
            $display("[FAIL] %0t ns: done high before the frame ended", $time);
            errors++;
        end
        compare_bytes();
        cycles = 0;
        while (o_done !== 1'b1 && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (o_done !== 1'b1) begin
            $display("done flag never rose after the value frame");
            errors++;
        end
        check_quiet(3, 1'b1);
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == first_err) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - first_err);
        end
        first_err = errors;
    endtask

    // LCD driver model that accepts each offered byte after 0 to 5 cycles
    initial begin : responder
        logic               pending;
        int unsigned        delay_left;
        lcd_pkg::lcd_byte_t held_data;
        lcd_pkg::lcd_func_t held_func;
        done_lcd = 1'b0;
        pending = 1'b0;
        delay_left = 0;
        held_data = '0;
        held_func = '0;
        forever begin
            @(posedge clk);
            #2;
            done_lcd = 1'b0;
            if (pending) begin
                // offered byte must hold until taken
                if (!o_en_lcd || o_data !== held_data || o_func !== held_func) begin
                    $display("[FAIL] %0t ns: offered byte 0x%02h changed before acceptance",
                             $time, held_data);
                    errors++;
                end
            end else if (o_en_lcd) begin
                pending = 1'b1;
                held_data = o_data;
                held_func = o_func;
                delay_left = $urandom % 6;
            end
            if (pending) begin
                if (delay_left == 0) begin
                    done_lcd = 1'b1;
                    got_data.push_back(o_data);
                    got_func.push_back(o_func);
                    pending = 1'b0;
                end else begin
                    delay_left--;
                end
            end
        end
    end

    initial begin : stimulus
        int unsigned seed;
        int          settled;
        // seed the generator once
        seed = $urandom(43);
        settled = 0;
        en_lcd = 1'b0;
        done_piso = 1'b0;
        done_sipo = 1'b0;
        conv = '0;
        data = '0;

        // outputs zero in reset and for two cycles after it
        @(negedge clk);
        while (!rst_n || settled < 2) begin
            if (o_en_lcd !== 1'b0 || o_done !== 1'b0 || o_data !== '0 || o_func !== '0) begin
                $display("[FAIL] %0t ns: outputs not zero around reset", $time);
                errors++;
            end
            if (rst_n)
                settled++;
            @(negedge clk);
        end
        expect_byte(8'h00, `LCD_FUNC_INIT);
        wait_bytes(1);
        compare_bytes();
        close_test("reset and init byte");

        // idle holds until enabled
        check_quiet(20, 1'b0);
        @(posedge clk);
        #2;
        en_lcd = 1'b1;
        expect_label_line("idata =", `LCD_CMD_LINE1);
        expect_label_line("odata =", `LCD_CMD_LINE2);
        wait_bytes(16);
        compare_bytes();
        close_test("label lines");

        check_quiet(10, 1'b0);
        run_frame($urandom, $urandom);
        close_test("first value frame");

        // done holds through wait and clears on the next conversion
        check_quiet(10, 1'b1);
        pulse_conv($urandom);
        @(negedge clk);
        if (o_done !== 1'b0) begin
            $display("[FAIL] %0t ns: done not cleared by conversion pulse", $time);
            errors++;
        end
        close_test("done flag");

        for (int f = 0; f < FRAMES; f++)
            run_frame($urandom, $urandom);
        close_test("random frames");

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;
    end

    // reset low for ten rising edges, released just after the tenth
    initial begin
        o_rst_n = 1'b0;
        repeat (10) @(posedge o_clk);
        #2 o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== lcd_control.sv ====
`default_nettype none

module lcd_control (
    input  wire                      i_clk,
    input  wire                      i_rst_n,
    input  wire                      i_en_lcd,
    input  wire                      i_done_piso,
    input  wire                      i_done_sipo,
    input  wire                      i_done_lcd,
    input  wire lcd_pkg::conv_word_t i_conv,
    input  wire lcd_pkg::lcd_byte_t  i_data,
    output logic                     o_en_lcd,
    output lcd_pkg::lcd_byte_t       o_data,
    output lcd_pkg::lcd_func_t       o_func,
    output logic                     o_done
);

    // sequencer position toward the table
    lcd_pkg::display_phase_t phase;
    lcd_pkg::char_idx_t      char_idx;
    // table output, registered by the sequencer
    lcd_pkg::lcd_byte_t      next_char;
    lcd_pkg::lcd_func_t      next_func;

    // value latches and byte table
    lcd_field_formatter u_formatter (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_done_piso (i_done_piso),
        .i_done_sipo (i_done_sipo),
        .i_conv      (i_conv),
        .i_data      (i_data),
        .i_phase     (phase),
        .i_char_idx  (char_idx),
        .o_next_char (next_char),
        .o_next_func (next_func)
    );

    // phase FSM and byte handshake
    lcd_sequencer u_sequencer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_en_lcd    (i_en_lcd),
        .i_done_lcd  (i_done_lcd),
        .i_done_sipo (i_done_sipo),
        .i_done_piso (i_done_piso),
        .i_next_char (next_char),
        .i_next_func (next_func),
        .o_phase     (phase),
        .o_char_idx  (char_idx),
        .o_en_lcd    (o_en_lcd),
        .o_data      (o_data),
        .o_func      (o_func),
        .o_done      (o_done)
    );

endmodule

`default_nettype wire

// ==== lcd_sequencer.sv ====
`default_nettype none

`include "lcd_config.svh"

module lcd_sequencer (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_en_lcd,
    input  wire                     i_done_lcd,
    input  wire                     i_done_sipo,
    input  wire                     i_done_piso,
    input  wire lcd_pkg::lcd_byte_t i_next_char,
    input  wire lcd_pkg::lcd_func_t i_next_func,
    output lcd_pkg::display_phase_t o_phase,
    output lcd_pkg::char_idx_t      o_char_idx,
    output logic                    o_en_lcd,
    output lcd_pkg::lcd_byte_t      o_data,
    output lcd_pkg::lcd_func_t      o_func,
    output logic                    o_done
);

    lcd_pkg::display_phase_t phase_next;
    // byte offered and taken by the driver in this cycle
    logic                    accept;
    // counter sits on the last byte of the running sequence
    logic                    at_last;
    // phase walks a character sequence
    logic                    in_seq;

    assign accept = i_done_lcd && o_en_lcd;
    assign in_seq = (o_phase == lcd_pkg::PH_LABEL) || (o_phase == lcd_pkg::PH_VALUE);

    always_comb begin
        case (o_phase)
            lcd_pkg::PH_LABEL:
                at_last = (o_char_idx == lcd_pkg::char_idx_t'(`LCD_LABEL_LAST));
            lcd_pkg::PH_VALUE:
                at_last = (o_char_idx == lcd_pkg::char_idx_t'(`LCD_VALUE_LAST));
            default:
                at_last = 1'b0;
        endcase
    end

    // phase FSM
    always_comb begin
        case (o_phase)
            lcd_pkg::PH_RESET:
                phase_next = lcd_pkg::PH_INIT;
            // init byte done, any driver pulse counts here
            lcd_pkg::PH_INIT:
                phase_next = i_done_lcd ? lcd_pkg::PH_IDLE : lcd_pkg::PH_INIT;
            lcd_pkg::PH_IDLE:
                phase_next = i_en_lcd ? lcd_pkg::PH_LABEL : lcd_pkg::PH_IDLE;
            lcd_pkg::PH_LABEL:
                phase_next = (accept && at_last) ? lcd_pkg::PH_WAIT : lcd_pkg::PH_LABEL;
            lcd_pkg::PH_WAIT:
                phase_next = i_done_sipo ? lcd_pkg::PH_VALUE : lcd_pkg::PH_WAIT;
            lcd_pkg::PH_VALUE:
                phase_next = (accept && at_last) ? lcd_pkg::PH_DONE : lcd_pkg::PH_VALUE;
            // single cycle, then back for the next word
            lcd_pkg::PH_DONE:
                phase_next = lcd_pkg::PH_WAIT;
            default:
                phase_next = lcd_pkg::PH_RESET;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_phase <= lcd_pkg::PH_RESET;
        else
            o_phase <= phase_next;
    end

    // character counter, one step per accepted byte
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_char_idx <= '0;
        else if (!in_seq)
            o_char_idx <= '0;
        else if (accept)
            o_char_idx <= at_last ? '0 : o_char_idx + 1'b1;
    end

    // outputs one cycle behind phase and index
    // enable drops for one cycle after each acceptance
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_en_lcd <= 1'b0;
            o_data   <= '0;
            o_func   <= '0;
        end else begin
            case (o_phase)
                lcd_pkg::PH_INIT, lcd_pkg::PH_LABEL, lcd_pkg::PH_VALUE: begin
                    o_en_lcd <= !i_done_lcd;
                    o_data   <= i_next_char;
                    o_func   <= i_next_func;
                end
                default: begin
                    o_en_lcd <= 1'b0;
                    o_data   <= '0;
                    o_func   <= '0;
                end
            endcase
        end
    end

    // done flag, held until the next conversion result
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_done <= 1'b0;
        end else if (o_phase == lcd_pkg::PH_DONE) begin
            o_done <= 1'b1;
        end else if (i_done_piso) begin
            // only quiet phases clear it
            if (o_phase == lcd_pkg::PH_RESET || o_phase == lcd_pkg::PH_IDLE ||
                o_phase == lcd_pkg::PH_WAIT)
                o_done <= 1'b0;
        end
    end

    // no encoding outside the seven phases
    a_phase_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_phase inside {lcd_pkg::PH_RESET, lcd_pkg::PH_INIT, lcd_pkg::PH_IDLE,
                        lcd_pkg::PH_LABEL, lcd_pkg::PH_WAIT, lcd_pkg::PH_VALUE,
                        lcd_pkg::PH_DONE})
        else $error("phase left the legal set");

    // value frame never walks past its last byte
    a_value_idx: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_phase == lcd_pkg::PH_VALUE) |->
            (o_char_idx <= lcd_pkg::char_idx_t'(`LCD_VALUE_LAST)))
        else $error("value index beyond frame");

    // conversion result arrives before the data word,
    // so done is gone before a frame offers bytes
    a_en_done: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_en_lcd && o_done))
        else $error("byte offered while done still high");

endmodule

`default_nettype wire

// ==== lcd_field_formatter.sv ====
`default_nettype none

`include "lcd_config.svh"

module lcd_field_formatter (
    input  wire                          i_clk,
    input  wire                          i_rst_n,
    input  wire                          i_done_piso,
    input  wire                          i_done_sipo,
    input  wire lcd_pkg::conv_word_t     i_conv,
    input  wire lcd_pkg::lcd_byte_t      i_data,
    input  wire lcd_pkg::display_phase_t i_phase,
    input  wire lcd_pkg::char_idx_t      i_char_idx,
    output lcd_pkg::lcd_byte_t           o_next_char,
    output lcd_pkg::lcd_func_t           o_next_func
);

    // held values from the last pulses
    lcd_pkg::conv_word_t conv_q;
    lcd_pkg::lcd_byte_t  data_q;
    // values seen by the table, new input during the pulse cycle
    lcd_pkg::conv_word_t conv_cur;
    lcd_pkg::lcd_byte_t  data_cur;
    // label line select, upper half of the label is line 2
    logic                label_line2;

    // nibble to ascii, upper case letters
    function automatic lcd_pkg::lcd_byte_t hex_ascii(input logic [3:0] nib);
        lcd_pkg::lcd_byte_t wide;
        wide = {4'd0, nib};
        if (nib < 4'd10)
            return `LCD_CHR_ZERO + wide;
        else
            return `LCD_CHR_A_UC + wide - 8'd10;
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            conv_q <= '0;
            data_q <= '0;
        end else begin
            // conversion done carries the word
            if (i_done_piso)
                conv_q <= i_conv;
            // serial-in done carries the byte
            if (i_done_sipo)
                data_q <= i_data;
        end
    end

    // bypass so a frame started on the pulse shows the new value
    assign conv_cur    = i_done_piso ? i_conv : conv_q;
    assign data_cur    = i_done_sipo ? i_data : data_q;
    assign label_line2 = i_char_idx[3];

    always_comb begin
        // init byte is 0 with function init
        o_next_char = '0;
        o_next_func = `LCD_FUNC_INIT;
        case (i_phase)
            lcd_pkg::PH_LABEL: begin
                o_next_func = `LCD_FUNC_DATA;
                // both lines share one layout, only cursor and first letter differ
                case (i_char_idx[2:0])
                    3'd0: begin
                        o_next_char = label_line2 ? `LCD_CMD_LINE2 : `LCD_CMD_LINE1;
                        o_next_func = `LCD_FUNC_SETCURSOR;
                    end
                    3'd1: o_next_char = label_line2 ? `LCD_CHR_O_LC : `LCD_CHR_I_LC;
                    3'd2: o_next_char = `LCD_CHR_D_LC;
                    3'd3: o_next_char = `LCD_CHR_A_LC;
                    3'd4: o_next_char = `LCD_CHR_T_LC;
                    3'd5: o_next_char = `LCD_CHR_A_LC;
                    3'd6: o_next_char = `LCD_CHR_SPACE;
                    default: o_next_char = `LCD_CHR_EQUAL;
                endcase
            end
            lcd_pkg::PH_VALUE: begin
                o_next_func = `LCD_FUNC_DATA;
                case (i_char_idx)
                    // clear, then cursor to the value column of line 1
                    4'd0: begin
                        o_next_char = `LCD_CMD_CLEAR;
                        o_next_func = `LCD_FUNC_CMD;
                    end
                    4'd1: begin
                        o_next_char = `LCD_CMD_LINE1 + `LCD_VALUE_COL;
                        o_next_func = `LCD_FUNC_CMD;
                    end
                    4'd2: o_next_char = `LCD_CHR_ZERO;
                    4'd3: o_next_char = `LCD_CHR_X_LC;
                    // conversion word, msb nibble first
                    4'd4: o_next_char = hex_ascii(conv_cur[15:12]);
                    4'd5: o_next_char = hex_ascii(conv_cur[11:8]);
                    4'd6: o_next_char = hex_ascii(conv_cur[7:4]);
                    4'd7: o_next_char = hex_ascii(conv_cur[3:0]);
                    // line 2 holds the data byte
                    4'd8: begin
                        o_next_char = `LCD_CMD_LINE2 + `LCD_VALUE_COL;
                        o_next_func = `LCD_FUNC_CMD;
                    end
                    4'd9: o_next_char = `LCD_CHR_ZERO;
                    4'd10: o_next_char = `LCD_CHR_X_LC;
                    4'd11: o_next_char = hex_ascii(data_cur[7:4]);
                    4'd12: o_next_char = hex_ascii(data_cur[3:0]);
                    // past the frame, fall back to the init byte
                    default: begin
                        o_next_char = '0;
                        o_next_func = `LCD_FUNC_INIT;
                    end
                endcase
            end
            default: begin
                o_next_char = '0;
                o_next_func = `LCD_FUNC_INIT;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== lcd_pkg.sv ====
`default_nettype none

`include "lcd_config.svh"

package lcd_pkg;

    // one byte toward the LCD, command or character
    typedef logic [`LCD_DATA_W-1:0] lcd_byte_t;

    // driver function select
    typedef logic [`LCD_FUNC_W-1:0] lcd_func_t;

    // conversion result shown as four hex digits
    typedef logic [`LCD_CONV_W-1:0] conv_word_t;

    // position inside the label or value sequence
    typedef logic [`LCD_IDX_W-1:0] char_idx_t;

    // display phases
    // reset lasts one cycle, init sends the init byte
    // label writes both label lines once
    // wait and value loop for every new data word
    typedef enum logic [2:0] {
        PH_RESET = 3'd0,
        PH_INIT  = 3'd1,
        PH_IDLE  = 3'd2,
        PH_LABEL = 3'd3,
        PH_WAIT  = 3'd4,
        PH_VALUE = 3'd5,
        PH_DONE  = 3'd6
    } display_phase_t;

endpackage

`default_nettype wire

// ==== lcd_config.svh ====
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

// datapath widths
`define LCD_CONV_W      16
`define LCD_DATA_W      8
`define LCD_FUNC_W      2
`define LCD_IDX_W       4

// last character index of each sequence
`define LCD_LABEL_LAST  15
`define LCD_VALUE_LAST  12

// HD44780 style commands
`define LCD_CMD_CLEAR   8'h01
`define LCD_CMD_LINE1   8'h80
`define LCD_CMD_LINE2   8'hC0
// value field starts at this column on both lines
`define LCD_VALUE_COL   8'd7

// function codes toward the LCD driver
`define LCD_FUNC_INIT       2'd0
`define LCD_FUNC_SETCURSOR  2'd1
`define LCD_FUNC_CMD        2'd2
`define LCD_FUNC_DATA       2'd3

// ascii codes used by the labels and the value frame
`define LCD_CHR_I_LC    8'h69
`define LCD_CHR_O_LC    8'h6F
`define LCD_CHR_D_LC    8'h64
`define LCD_CHR_A_LC    8'h61
`define LCD_CHR_T_LC    8'h74
`define LCD_CHR_X_LC    8'h78
`define LCD_CHR_SPACE   8'h20
`define LCD_CHR_EQUAL   8'h3D
`define LCD_CHR_ZERO    8'h30
`define LCD_CHR_A_UC    8'h41

`endif
